// ==== files.f ====
hw/axi_pkg.sv
hw/axi_r_slice.sv
hw/axi_r_router.sv
hw/axi_r_xbar.sv
tb/axi_r_xbar_chk.sv
tb/tb_axi_r_xbar.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_axi_r_xbar
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The log decides the result, the simulator status alone does not
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/tb_axi_r_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_r_xbar;

  import axi_pkg::*;

  localparam int data_w   = 32;
  localparam int mid_w    = 4;
  localparam int sid_w    = mid_w + sel_w;
  localparam int n_rows   = 12;
  // Random master ready from this cycle on
  localparam int bp_cyc   = 70;
  localparam int lat_row  = 0;
  localparam int prio_row = 1;

  typedef struct packed {
    int               slv;
    int               mst;
    logic [mid_w-1:0] mid;
    int               len;
    resp_t            resp;
    int               start;
  } row_t;

  // slave, master, master ID, length, response, start cycle
  row_t tbl [n_rows] = '{
    '{1, 1, 4'h3, 1, okay,   12},
    '{0, 0, 4'h5, 3, okay,   30},
    '{1, 1, 4'h9, 2, exokay, 30},
    '{2, 0, 4'h2, 4, slverr, 30},
    '{0, 1, 4'ha, 4, okay,   80},
    '{1, 0, 4'h6, 2, decerr, 80},
    '{2, 1, 4'hf, 1, exokay, 82},
    '{0, 0, 4'h0, 2, okay,   84},
    '{2, 0, 4'h7, 3, slverr, 86},
    '{1, 1, 4'hc, 4, okay,   90},
    '{0, 1, 4'h1, 1, okay,   92},
    '{2, 1, 4'h4, 2, exokay, 95}
  };

  logic               clk = 1'b0;
  logic               rstn = 1'b0;
  logic [num_slv-1:0] s_vld = '0;
  logic [num_slv-1:0] s_last = '0;
  logic [sid_w-1:0]   s_id [num_slv] = '{default: '0};
  logic [data_w-1:0]  s_data [num_slv] = '{default: '0};
  logic [1:0]         s_resp [num_slv] = '{default: '0};
  wire  [num_slv-1:0] s_rdy;
  logic [num_mst-1:0] m_rdy = '0;
  wire  [num_mst-1:0] m_vld;
  wire  [num_mst-1:0] m_last;
  wire  [mid_w-1:0]   m_id [num_mst];
  wire  [data_w-1:0]  m_data [num_mst];
  wire  [1:0]         m_resp [num_mst];

  int     cyc = 0;
  integer seed = 32'h16dc;
  int     errors = 0;
  int     n_ok = 0;
  int     done_cnt = 0;
  int     cur_row [num_slv];
  int     beat_no [num_slv];
  int     open_row [num_mst];
  int     beat_cnt [num_mst];
  int     err_mark [num_mst];
  int     first_drive [n_rows];
  int     first_seen [n_rows];
  int     done_cyc [n_rows];
  int     exp_q [num_slv][$];

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  axi_r_xbar #(.data_w(data_w), .mid_w(mid_w)) axi_r_xbar_i (
    .clk, .rstn,
    .rvalid_s0(s_vld[0]), .rready_s0(s_rdy[0]), .rid_s0(s_id[0]),
    .rdata_s0(s_data[0]), .rresp_s0(s_resp[0]), .rlast_s0(s_last[0]),
    .rvalid_s1(s_vld[1]), .rready_s1(s_rdy[1]), .rid_s1(s_id[1]),
    .rdata_s1(s_data[1]), .rresp_s1(s_resp[1]), .rlast_s1(s_last[1]),
    .rvalid_s2(s_vld[2]), .rready_s2(s_rdy[2]), .rid_s2(s_id[2]),
    .rdata_s2(s_data[2]), .rresp_s2(s_resp[2]), .rlast_s2(s_last[2]),
    .rvalid_m0(m_vld[0]), .rready_m0(m_rdy[0]), .rid_m0(m_id[0]),
    .rdata_m0(m_data[0]), .rresp_m0(m_resp[0]), .rlast_m0(m_last[0]),
    .rvalid_m1(m_vld[1]), .rready_m1(m_rdy[1]), .rid_m1(m_id[1]),
    .rdata_m1(m_data[1]), .rresp_m1(m_resp[1]), .rlast_m1(m_last[1])
  );

  bind axi_r_router axi_r_xbar_chk #(.beat_w($bits(beat_q))) u_chk (
    .clk, .rstn, .lock(lock_q), .s_valid, .s_ready, .m_valid, .m_ready, .beat(beat_q)
  );

  function automatic int next_row(int s, int from);
    for (int r = from; r < n_rows; r++) begin
      if (tbl[r].slv == s) begin
        return r;
      end
    end
    return n_rows;
  endfunction

  // Source slave, table row, beat number, fixed tag
  function automatic logic [data_w-1:0] beat_data(int s, int r, int b);
    return {8'(s), 8'(r), 8'(b), 8'h3c};
  endfunction

  task automatic check_id(string sig, logic [mid_w-1:0] got, logic [mid_w-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h, expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic compare_data(string sig, logic [data_w-1:0] got, logic [data_w-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h, expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic verify_resp(string sig, resp_t got, resp_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %s, expected %s", $time, sig, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic expect_last(string sig, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b, expected %b", $time, sig, got, exp);
      errors++;
    end
  endtask

  // Slave drivers walk their own table rows
  always @(posedge clk) begin
    int r;
    if (!rstn) begin
      for (int s = 0; s < num_slv; s++) begin
        cur_row[s] = next_row(s, 0);
        beat_no[s] = 0;
      end
      first_drive = '{default: -1};
    end else begin
      for (int s = 0; s < num_slv; s++) begin
        if (s_vld[s] && s_rdy[s]) begin
          if (s_last[s]) begin
            cur_row[s] = next_row(s, cur_row[s] + 1);
            beat_no[s] = 0;
          end else begin
            beat_no[s] = beat_no[s] + 1;
          end
        end
        r = cur_row[s];
        if (r < n_rows && cyc >= tbl[r].start) begin
          if (first_drive[r] < 0) begin
            first_drive[r] = cyc;
          end
          s_vld[s]  <= 1'b1;
          s_id[s]   <= {tbl[r].mid, sel_w'(tbl[r].mst)};
          s_data[s] <= beat_data(s, r, beat_no[s]);
          s_resp[s] <= tbl[r].resp;
          s_last[s] <= (beat_no[s] == tbl[r].len - 1);
        end else begin
          s_vld[s] <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    int rnd;
    if (cyc < bp_cyc) begin
      m_rdy <= '1;
    end else begin
      rnd = $random(seed);
      m_rdy <= {|rnd[3:2], |rnd[1:0]};
    end
  end

  // Scoreboard keyed by the data of the first beat
  always @(posedge clk) begin
    int r;
    int s;
    int b;
    if (!rstn) begin
      for (int i = 0; i < num_slv; i++) begin
        exp_q[i].delete();
      end
      for (int i = 0; i < n_rows; i++) begin
        exp_q[tbl[i].slv].push_back(i);
      end
      open_row = '{default: -1};
      first_seen = '{default: -1};
      done_cyc = '{default: -1};
    end else begin
      for (int m = 0; m < num_mst; m++) begin
        if (m_vld[m] && m_rdy[m]) begin
          if (open_row[m] < 0) begin
            r = int'(m_data[m][23:16]);
            if (r >= n_rows) begin
              $display("master %0d got a beat that names no burst, data %h", m, m_data[m]);
              errors++;
            end else begin
              s = tbl[r].slv;
              if (exp_q[s].size() == 0 || exp_q[s][0] != r) begin
                $display("burst %0d of slave %0d arrived out of table order", r, s);
                errors++;
              end else begin
                void'(exp_q[s].pop_front());
              end
              if (tbl[r].mst != m) begin
                $display("burst %0d arrived at master %0d instead of %0d", r, m, tbl[r].mst);
                errors++;
              end
              open_row[m] = r;
              beat_cnt[m] = 0;
              err_mark[m] = errors;
              first_seen[r] = cyc;
            end
          end
          if (open_row[m] >= 0) begin
            r = open_row[m];
            s = tbl[r].slv;
            b = beat_cnt[m];
            check_id($sformatf("rid_m%0d", m), m_id[m], tbl[r].mid);
            compare_data($sformatf("rdata_m%0d", m), m_data[m], beat_data(s, r, b));
            verify_resp($sformatf("rresp_m%0d", m), resp_t'(m_resp[m]), tbl[r].resp);
            expect_last($sformatf("rlast_m%0d", m), m_last[m], b == tbl[r].len - 1);
            if (m_last[m] || b == tbl[r].len - 1) begin
              done_cyc[r] = cyc;
              done_cnt++;
              open_row[m] = -1;
              if (errors == err_mark[m]) begin
                n_ok++;
              end
              $display("burst %0d slave %0d -> master %0d, %0d beats: %s", r, s, m,
                       tbl[r].len, (errors == err_mark[m]) ? "ok" : "failed");
            end else begin
              beat_cnt[m] = b + 1;
            end
          end
        end
      end
    end
  end

  initial begin
    int limit;
    int last_start;
    int fin_errs;
    int lat;
    limit = 50;
    last_start = 0;
    fin_errs = 0;
    for (int r = 0; r < n_rows; r++) begin
      limit += tbl[r].len * 8;
      if (tbl[r].start > last_start) begin
        last_start = tbl[r].start;
      end
    end
    limit += last_start;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    while (done_cnt < n_rows && cyc < limit) begin
      @(negedge clk);
    end
    if (done_cnt < n_rows) begin
      $display("timeout after %0d cycles, %0d of %0d bursts done", cyc, done_cnt, n_rows);
      fin_errs++;
    end else begin
      // Idle time so that stray or repeated beats still show up
      repeat (20) @(posedge clk);
    end
    // First master sample comes one edge after rvalid rises
    lat = first_seen[lat_row] - first_drive[lat_row] - 1;
    if (lat != 3) begin
      $display("mismatch at %0t: rvalid_m%0d latency got %0d, expected 3", $time,
               tbl[lat_row].mst, lat);
      fin_errs++;
    end
    if (done_cyc[prio_row] < 0 || done_cyc[prio_row] >= done_cyc[prio_row + 1] ||
        done_cyc[prio_row + 1] >= done_cyc[prio_row + 2]) begin
      $display("same-cycle bursts of S0, S1 and S2 did not complete in priority order");
      fin_errs++;
    end
    $display("%0d of %0d bursts passed, %0d errors", n_ok, n_rows, errors + fin_errs);
    if (errors + fin_errs == 0 && done_cnt == n_rows) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/axi_r_xbar_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_r_xbar_chk #(
  parameter int beat_w = 1
) (
  input wire logic                          clk,
  input wire logic                          rstn,
  input wire axi_pkg::lock_t                lock,
  input wire logic [axi_pkg::num_slv-1:0]  s_valid,
  input wire logic [axi_pkg::num_slv-1:0]  s_ready,
  input wire logic [axi_pkg::num_mst-1:0]  m_valid,
  input wire logic [axi_pkg::num_mst-1:0]  m_ready,
  input wire logic [beat_w-1:0]            beat
);

  import axi_pkg::*;

  // A pop goes to one slave only, and that slave must hold a beat
  a_one_ready : assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(s_ready) && ((s_ready & ~s_valid) == '0))
    else $error("slave ready high for several slaves or for a slave without a beat");

  for (genvar s = 0; s < num_slv; s++) begin : g_slv
    a_lock_ready : assert property (@(posedge clk) disable iff (!rstn)
      s_ready[s] |-> lock == lock_t'(s + 1))
      else $error("slave %0d ready outside its lock", s);
  end

  // All masters are fed from the one latched beat
  for (genvar m = 0; m < num_mst; m++) begin : g_mst
    a_hold : assert property (@(posedge clk) disable iff (!rstn)
      m_valid[m] && !m_ready[m] |=> m_valid[m] && $stable(beat))
      else $error("master %0d beat dropped or changed before ready", m);
  end

endmodule

`default_nettype wire

// ==== hw/axi_r_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_r_xbar #(
  parameter int data_w = 32,
  parameter int mid_w  = 4
) (
  input  wire logic                              clk,
  input  wire logic                              rstn,
  // Slave 0
  input  wire logic                              rvalid_s0,
  output logic                                   rready_s0,
  input  wire logic [mid_w+axi_pkg::sel_w-1:0]  rid_s0,
  input  wire logic [data_w-1:0]                rdata_s0,
  input  wire logic [1:0]                       rresp_s0,
  input  wire logic                              rlast_s0,
  // Slave 1
  input  wire logic                              rvalid_s1,
  output logic                                   rready_s1,
  input  wire logic [mid_w+axi_pkg::sel_w-1:0]  rid_s1,
  input  wire logic [data_w-1:0]                rdata_s1,
  input  wire logic [1:0]                       rresp_s1,
  input  wire logic                              rlast_s1,
  // Slave 2
  input  wire logic                              rvalid_s2,
  output logic                                   rready_s2,
  input  wire logic [mid_w+axi_pkg::sel_w-1:0]  rid_s2,
  input  wire logic [data_w-1:0]                rdata_s2,
  input  wire logic [1:0]                       rresp_s2,
  input  wire logic                              rlast_s2,
  // Master 0
  output logic                                   rvalid_m0,
  input  wire logic                              rready_m0,
  output logic      [mid_w-1:0]                 rid_m0,
  output logic      [data_w-1:0]                rdata_m0,
  output logic      [1:0]                       rresp_m0,
  output logic                                   rlast_m0,
  // Master 1
  output logic                                   rvalid_m1,
  input  wire logic                              rready_m1,
  output logic      [mid_w-1:0]                 rid_m1,
  output logic      [data_w-1:0]                rdata_m1,
  output logic      [1:0]                       rresp_m1,
  output logic                                   rlast_m1
);

  import axi_pkg::*;

  localparam int sid_w = mid_w + sel_w;

  typedef struct packed {
    logic [sid_w-1:0]  id;
    logic [data_w-1:0] data;
    resp_t             resp;
    logic              last;
  } s_beat_t;

  typedef struct packed {
    logic [mid_w-1:0]  id;
    logic [data_w-1:0] data;
    resp_t             resp;
    logic              last;
  } m_beat_t;

  // Port side of the slave slices
  logic [num_slv-1:0] si_valid;
  logic [num_slv-1:0] si_ready;
  s_beat_t            si_beat [num_slv];
  // Router side
  logic [num_slv-1:0] s_valid;
  logic [num_slv-1:0] s_ready;
  s_beat_t            s_beat [num_slv];
  logic [num_mst-1:0] m_valid;
  logic [num_mst-1:0] m_ready;
  m_beat_t            m_beat [num_mst];
  // Port side of the master slices
  logic [num_mst-1:0] mo_valid;
  logic [num_mst-1:0] mo_ready;
  m_beat_t            mo_beat [num_mst];

  assign si_valid = {rvalid_s2, rvalid_s1, rvalid_s0};
  assign {rready_s2, rready_s1, rready_s0} = si_ready;

  always_comb begin
    si_beat[0] = '{id: rid_s0, data: rdata_s0, resp: resp_t'(rresp_s0), last: rlast_s0};
    si_beat[1] = '{id: rid_s1, data: rdata_s1, resp: resp_t'(rresp_s1), last: rlast_s1};
    si_beat[2] = '{id: rid_s2, data: rdata_s2, resp: resp_t'(rresp_s2), last: rlast_s2};
  end

  for (genvar s = 0; s < num_slv; s++) begin : g_slv
    axi_r_slice #(.beat_t(s_beat_t)) u_slice (
      .clk,
      .rstn,
      .in_valid  (si_valid[s]),
      .in_ready  (si_ready[s]),
      .in_beat   (si_beat[s]),
      .out_valid (s_valid[s]),
      .out_ready (s_ready[s]),
      .out_beat  (s_beat[s])
    );
  end

  axi_r_router #(
    .data_w   (data_w),
    .mid_w    (mid_w),
    .s_beat_t (s_beat_t),
    .m_beat_t (m_beat_t)
  ) u_router (
    .clk,
    .rstn,
    .s_valid,
    .s_ready,
    .s_beat,
    .m_valid,
    .m_ready,
    .m_beat
  );

  for (genvar m = 0; m < num_mst; m++) begin : g_mst
    axi_r_slice #(.beat_t(m_beat_t)) u_slice (
      .clk,
      .rstn,
      .in_valid  (m_valid[m]),
      .in_ready  (m_ready[m]),
      .in_beat   (m_beat[m]),
      .out_valid (mo_valid[m]),
      .out_ready (mo_ready[m]),
      .out_beat  (mo_beat[m])
    );
  end

  assign mo_ready = {rready_m1, rready_m0};

  // Unpack master beats onto the AXI R ports
  assign rvalid_m0 = mo_valid[0];
  assign rid_m0    = mo_beat[0].id;
  assign rdata_m0  = mo_beat[0].data;
  assign rresp_m0  = mo_beat[0].resp;
  assign rlast_m0  = mo_beat[0].last;

  assign rvalid_m1 = mo_valid[1];
  assign rid_m1    = mo_beat[1].id;
  assign rdata_m1  = mo_beat[1].data;
  assign rresp_m1  = mo_beat[1].resp;
  assign rlast_m1  = mo_beat[1].last;

endmodule

`default_nettype wire

// ==== hw/axi_r_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_r_router #(
  parameter int  data_w   = 32,
  parameter int  mid_w    = 4,
  parameter type s_beat_t = logic,
  parameter type m_beat_t = logic
) (
  input  wire logic                         clk,
  input  wire logic                         rstn,
  input  wire logic [axi_pkg::num_slv-1:0] s_valid,
  output logic      [axi_pkg::num_slv-1:0] s_ready,
  input  wire s_beat_t                      s_beat [axi_pkg::num_slv],
  output logic      [axi_pkg::num_mst-1:0] m_valid,
  input  wire logic [axi_pkg::num_mst-1:0] m_ready,
  output m_beat_t                           m_beat [axi_pkg::num_mst]
);

  import axi_pkg::*;

  localparam int sid_w = mid_w + sel_w;
  localparam int idx_w = $clog2(num_slv);

  lock_t             lock_q;
  lock_t             lock_d;
  s_beat_t           beat_q;
  logic              beat_vld;
  logic              vld_d;
  logic              load;
  logic [idx_w-1:0]  cur;
  logic [idx_w-1:0]  pick;
  logic [idx_w-1:0]  load_idx;
  logic              any_valid;
  logic [sid_w-1:0]  sid;
  logic [sel_w-1:0]  dst;
  logic [mid_w-1:0]  fwd_id;
  logic [data_w-1:0] fwd_data;
  logic              xfer;

  // Slave index held by the current lock
  always_comb begin
    case (lock_q)
      lock_s1: cur = idx_w'(1);
      lock_s2: cur = idx_w'(2);
      default: cur = idx_w'(0);
    endcase
  end

  // Fixed priority, lowest slave index wins
  always_comb begin
    any_valid = 1'b0;
    pick      = '0;
    for (int i = num_slv - 1; i >= 0; i--) begin
      if (s_valid[i]) begin
        any_valid = 1'b1;
        pick      = idx_w'(i);
      end
    end
  end

  assign sid      = beat_q.id;
  assign dst      = sid[sel_w-1:0];
  assign fwd_id   = sid[sid_w-1:sel_w];
  assign fwd_data = beat_q.data;
  assign xfer     = beat_vld && m_ready[dst];

  always_comb begin
    lock_d = lock_q;
    vld_d  = beat_vld;
    load   = 1'b0;
    if (lock_q == lock_no) begin
      if (any_valid) begin
        case (pick)
          idx_w'(0): lock_d = lock_s0;
          idx_w'(1): lock_d = lock_s1;
          default:   lock_d = lock_s2;
        endcase
        vld_d = 1'b1;
        load  = 1'b1;
      end
    end else if (beat_vld) begin
      if (xfer) begin
        vld_d = 1'b0;
        // Burst done, release the grant
        if (beat_q.last) begin
          lock_d = lock_no;
        end
      end
    end else if (s_valid[cur]) begin
      vld_d = 1'b1;
      load  = 1'b1;
    end
  end

  assign load_idx = (lock_q == lock_no) ? pick : cur;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q   <= lock_no;
      beat_vld <= 1'b0;
    end else begin
      lock_q   <= lock_d;
      beat_vld <= vld_d;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      beat_q <= s_beat[load_idx];
    end
  end

  // Pop the slave beat together with the master transfer
  always_comb begin
    for (int i = 0; i < num_slv; i++) begin
      s_ready[i] = xfer && (cur == idx_w'(i));
    end
  end

  always_comb begin
    for (int m = 0; m < num_mst; m++) begin
      m_valid[m]     = beat_vld && (dst == sel_w'(m));
      m_beat[m].id   = fwd_id;
      m_beat[m].data = fwd_data;
      m_beat[m].resp = beat_q.resp;
      m_beat[m].last = beat_q.last;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_r_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_r_slice #(
  parameter type beat_t = logic
) (
  input  wire logic  clk,
  input  wire logic  rstn,
  input  wire logic  in_valid,
  output logic       in_ready,
  input  wire beat_t in_beat,
  output logic       out_valid,
  input  wire logic  out_ready,
  output beat_t      out_beat
);

  logic  skid_valid;
  beat_t skid_beat;
  logic  out_free;

  // Output register can take a new beat this cycle
  assign out_free = !out_valid || out_ready;

  // Ready only depends on the skid entry, so no path from out_ready
  assign in_ready = !skid_valid;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_free) begin
        if (skid_valid) begin
          out_valid  <= 1'b1;
          skid_valid <= 1'b0;
        end else begin
          out_valid <= in_valid;
        end
      end else if (in_valid && in_ready) begin
        // Output stalled, park the beat
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      if (out_free) begin
        out_beat <= in_beat;
      end else begin
        skid_beat <= in_beat;
      end
    end else if (skid_valid && out_ready) begin
      out_beat <= skid_beat;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  // Port counts of the read return path
  localparam int num_slv = 3;
  localparam int num_mst = 2;

  // Master index field in the low bits of the slave-side ID
  localparam int sel_w = 1;

  // AXI read response
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } resp_t;

  // Grant state of the router, one lock per slave
  typedef enum logic [1:0] {
    lock_no = 2'd0,
    lock_s0 = 2'd1,
    lock_s1 = 2'd2,
    lock_s2 = 2'd3
  } lock_t;

endpackage

`default_nettype wire
